// ==== source/icache_params.svh ====
/*
  Instruction cache geometry
  Two-way, 16 sets, 4-word lines on a 32-bit fetch path
*/
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Base geometry
`define ICACHE_XLEN        32            // Word and address width
`define ICACHE_WAYS        2             // Ways per set
`define ICACHE_SETS        16            // Sets per way
`define ICACHE_LINE_WORDS  4             // Words per line, also burst length

// Derived widths
`define ICACHE_BYTE_BITS   $clog2(`ICACHE_XLEN/8)    // Byte offset in a word
`define ICACHE_IDX_BITS    $clog2(`ICACHE_SETS)      // Set index
`define ICACHE_OFF_BITS    $clog2(`ICACHE_LINE_WORDS) // Word offset in a line
`define ICACHE_TAG_BITS    (`ICACHE_XLEN - `ICACHE_IDX_BITS - `ICACHE_OFF_BITS - \
                            `ICACHE_BYTE_BITS)
`define ICACHE_AGE_BITS    $clog2(`ICACHE_WAYS)      // FIFO age per way

`endif

// ==== source/icache_pkg.sv ====
/*
  Instruction cache types
  Request, parcel, bus and way command structs built from the geometry
*/
`default_nettype none

`include "icache_params.svh"

package icache_pkg;

  typedef logic [`ICACHE_XLEN-1:0]                         word_t;
  typedef logic [`ICACHE_TAG_BITS-1:0]                     tag_t;
  typedef logic [`ICACHE_IDX_BITS-1:0]                     idx_t;   // Set index
  typedef logic [`ICACHE_IDX_BITS+`ICACHE_OFF_BITS-1:0]    didx_t;  // Set and word offset

  // CPU side
  typedef struct packed {
    logic  valid;
    word_t pc;
  } fetch_req_t;

  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t word;
  } parcel_t;

  // Bus side
  typedef struct packed {
    logic  stb;
    word_t adr;                                     // Critical word first
  } bus_req_t;

  typedef struct packed {
    logic  rack;                                    // One per returned word
    word_t adr;
    word_t dat;
  } bus_rsp_t;

  // Tag memory word
  typedef struct packed {
    logic [`ICACHE_AGE_BITS-1:0] age;               // Zero marks the oldest way
    logic                        valid;
    tag_t                        tag;
  } tag_entry_t;

  // Controller to ways
  typedef struct packed {
    idx_t  tag_idx;
    didx_t dat_idx;
    logic  flush;                                   // Invalidate set tag_idx
    logic  fill;                                    // Bus word arriving
    logic  last;                                    // Last word, update tags
    tag_t  tag;
    word_t data;
  } way_wr_t;

  typedef struct packed {
    didx_t idx;                                     // Next lookup address
    tag_t  tag;                                     // Registered pc tag
  } way_rd_t;

endpackage

`default_nettype wire

// ==== source/icache_ram_1r1w.sv ====
/*
  Single read, single write port memory with registered read
*/
`default_nettype none

module icache_ram_1r1w #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2
) (
  input  logic                     clk,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  logic                     we,
  input  payload_t                 din,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output payload_t                 dout
);

  payload_t mem [DEPTH];                        // Contents undefined until written

  // Write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= din;
    end
  end

  // Read port, old data on a same-address collision
  always_ff @(posedge clk) begin
    dout <= mem[raddr];
  end

endmodule

`default_nettype wire

// ==== source/icache_way.sv ====
/*
  One cache way: tag and data memories, tag compare and FIFO age update
*/
`default_nettype none

`include "icache_params.svh"

module icache_way (
  input  logic                   clk,
  input  logic                   rstn,
  input  icache_pkg::way_wr_t    way_wr,
  input  icache_pkg::way_rd_t    way_rd,
  input  logic                   victim_sel,       // This way gets the fill
  output icache_pkg::tag_entry_t tag_out,
  output icache_pkg::word_t      data_out,
  output logic                   hit
);
  import icache_pkg::*;

  tag_entry_t tag_in;
  logic       tag_we;
  logic       dat_we;
  logic       tag_ok;                               // All sets invalidated once

  ////////////////////////////////////////////////////////////////////////////
  // Memories

  icache_ram_1r1w #(.payload_t(tag_entry_t), .DEPTH(`ICACHE_SETS)) tag_ram_i (
    .clk   (clk),
    .waddr (way_wr.tag_idx),
    .we    (tag_we),
    .din   (tag_in),
    .raddr (way_rd.idx[`ICACHE_OFF_BITS +: `ICACHE_IDX_BITS]),
    .dout  (tag_out)
  );

  icache_ram_1r1w #(.payload_t(word_t), .DEPTH(`ICACHE_SETS*`ICACHE_LINE_WORDS)) dat_ram_i (
    .clk   (clk),
    .waddr (way_wr.dat_idx),
    .we    (dat_we),
    .din   (way_wr.data),
    .raddr (way_rd.idx),
    .dout  (data_out)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Tag update

  assign dat_we = way_wr.fill & victim_sel;         // Only the victim takes bus words
  assign tag_we = way_wr.flush | way_wr.last;       // All ways age on the last word

  always_comb begin
    tag_in = tag_out;                               // Non-victim keeps tag and valid
    if (way_wr.flush) begin
      tag_in = '0;
    end else if (victim_sel) begin
      tag_in.age   = '1;                            // Newest line
      tag_in.valid = 1'b1;
      tag_in.tag   = way_wr.tag;
    end else if (|tag_out.age) begin
      tag_in.age = tag_out.age - 1'b1;              // Saturates at oldest
    end
  end

  // Tag RAM is garbage until the first full invalidate pass
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      tag_ok <= 1'b0;
    end else if (way_wr.flush && way_wr.tag_idx == idx_t'(`ICACHE_SETS - 1)) begin
      tag_ok <= 1'b1;
    end
  end

  assign hit = tag_ok & tag_out.valid & (tag_out.tag == way_rd.tag);

endmodule

`default_nettype wire

// ==== source/icache_way_merge.sv ====
/*
  Way merge: hit flag, hit data mux and FIFO victim pick across all ways
*/
`default_nettype none

`include "icache_params.svh"

module icache_way_merge (
  input  icache_pkg::tag_entry_t  tag_out  [`ICACHE_WAYS],
  input  icache_pkg::word_t       data_out [`ICACHE_WAYS],
  input  logic [`ICACHE_WAYS-1:0] hit,
  output logic                    cache_hit,
  output icache_pkg::word_t       hit_data,
  output logic [`ICACHE_WAYS-1:0] victim           // One-hot
);
  import icache_pkg::*;

  word_t                   and_or [`ICACHE_WAYS];  // Running OR of masked data
  logic [`ICACHE_WAYS-1:0] free;                   // Invalid or oldest

  genvar w;

  generate
    for (w = 0; w < `ICACHE_WAYS; w++) begin : g_way
      assign free[w] = ~tag_out[w].valid | ~|tag_out[w].age;

      if (w == 0) begin : g_first
        assign and_or[w] = data_out[w] & {`ICACHE_XLEN{hit[w]}};
        // Fall back to way 0 if no way qualifies
        assign victim[w] = free[w] | ~|free;
      end else begin : g_rest
        assign and_or[w] = (data_out[w] & {`ICACHE_XLEN{hit[w]}}) | and_or[w-1];
        // Lowest free way wins
        assign victim[w] = free[w] & ~|free[w-1:0];
      end
    end
  endgenerate

  assign cache_hit = |hit;                          // At most one way hits
  assign hit_data  = and_or[`ICACHE_WAYS-1];

endmodule

`default_nettype wire

// ==== source/icache_ctrl.sv ====
/*
  Cache controller: flush/armed/fill FSM, lookup pc, line request on miss
  and parcel output from a hit or the forwarded critical word
*/
`default_nettype none

`include "icache_params.svh"

module icache_ctrl (
  input  logic                  clk,
  input  logic                  rstn,
  input  icache_pkg::fetch_req_t fetch_req,
  output logic                  fetch_ready,
  input  logic                  cache_flush,
  output icache_pkg::parcel_t   parcel,
  output icache_pkg::bus_req_t  bus_req,
  input  logic                  bus_ack,
  input  icache_pkg::bus_rsp_t  bus_rsp,
  input  logic                  cache_hit,
  input  icache_pkg::word_t     hit_data,
  output icache_pkg::way_wr_t   way_wr,
  output icache_pkg::way_rd_t   way_rd
);
  import icache_pkg::*;

  localparam int LAST_SET  = `ICACHE_SETS - 1;
  localparam int LAST_WORD = `ICACHE_LINE_WORDS - 1;
  localparam int DIDX_LSB  = `ICACHE_BYTE_BITS;
  localparam int DIDX_BITS = `ICACHE_IDX_BITS + `ICACHE_OFF_BITS;
  localparam int SET_LSB   = `ICACHE_BYTE_BITS + `ICACHE_OFF_BITS;

  typedef enum logic [1:0] {
    FLUSH,
    ARMED,
    FILL
  } state_t;

  state_t state;
  idx_t   cnt;                                      // Sets in FLUSH, words in FILL
  logic   flushing;
  logic   filling;
  logic   flush_hold;                               // Flush seen outside FLUSH
  logic   flush_pend;
  logic   stb;
  word_t  pc;                                       // Pc under lookup
  logic   pc_valid;
  logic   accept;
  logic   miss;
  logic   hit_now;
  logic   crit_rack;                                // Bus word for the missed pc
  logic   fill_last;
  logic   parcel_vld;
  word_t  parcel_pc;
  word_t  parcel_word;

  assign flushing   = (state == FLUSH);
  assign filling    = (state == FILL);
  assign flush_pend = cache_flush | flush_hold;
  assign miss       = pc_valid & ~cache_hit;
  assign hit_now    = pc_valid & cache_hit;
  assign crit_rack  = filling & bus_rsp.rack & (bus_rsp.adr == pc);
  assign fill_last  = filling & bus_rsp.rack & (cnt == idx_t'(LAST_WORD));

  // Drops in the lookup cycle of a miss, and ahead of a flush
  assign fetch_ready = (state == ARMED) & ~miss & ~flush_pend;
  assign accept      = fetch_req.valid & fetch_ready;

  ////////////////////////////////////////////////////////////////////////////
  // FSM

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= FLUSH;                               // Invalidate all sets after reset
      cnt   <= '0;
      stb   <= 1'b0;
    end else begin
      case (state)
        FLUSH: begin
          cnt <= cnt + 1'b1;                        // One set per cycle
          if (cnt == idx_t'(LAST_SET)) begin
            cnt   <= '0;
            state <= ARMED;
          end
        end
        ARMED: begin
          cnt <= '0;
          if (miss) begin
            state <= FILL;
            stb   <= 1'b1;
          end else if (flush_pend && !pc_valid) begin
            state <= FLUSH;                         // Last hit parcel already out
          end
        end
        FILL: begin
          if (bus_ack) stb <= 1'b0;                 // Request phase over
          if (bus_rsp.rack) cnt <= cnt + 1'b1;
          if (fill_last) begin
            cnt   <= '0;
            state <= flush_pend ? FLUSH : ARMED;    // Held flush taken here
          end
        end
        default: state <= FLUSH;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      flush_hold <= 1'b0;
    end else begin
      flush_hold <= flush_pend & ~flushing;
    end
  end

  // Lookup pc
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pc       <= '0;
      pc_valid <= 1'b0;
    end else begin
      pc_valid <= accept;
      if (accept) pc <= fetch_req.pc;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Parcel out, one cycle after the hit or the critical rack

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      parcel_vld <= 1'b0;
    end else begin
      parcel_vld <= hit_now | crit_rack;
    end
  end

  always_ff @(posedge clk) begin
    if (hit_now) begin
      parcel_pc   <= pc;
      parcel_word <= hit_data;
    end else if (crit_rack) begin
      parcel_pc   <= pc;
      parcel_word <= bus_rsp.dat;
    end
  end

  assign parcel.valid = parcel_vld;
  assign parcel.pc    = parcel_pc;
  assign parcel.word  = parcel_word;

  // Line request, wrapping from the critical word
  assign bus_req.stb = stb;
  assign bus_req.adr = pc;

  ////////////////////////////////////////////////////////////////////////////
  // Way commands

  assign way_wr.tag_idx = flushing ? cnt : pc[SET_LSB +: `ICACHE_IDX_BITS];
  assign way_wr.dat_idx = bus_rsp.adr[DIDX_LSB +: DIDX_BITS];
  assign way_wr.flush   = flushing;
  assign way_wr.fill    = filling & bus_rsp.rack;
  assign way_wr.last    = fill_last;
  assign way_wr.tag     = pc[`ICACHE_XLEN-1 -: `ICACHE_TAG_BITS];
  assign way_wr.data    = bus_rsp.dat;

  // Next address when accepting, else keep pc's set on the tag outputs
  assign way_rd.idx = fetch_ready ? fetch_req.pc[DIDX_LSB +: DIDX_BITS]
                                  : pc[DIDX_LSB +: DIDX_BITS];
  assign way_rd.tag = pc[`ICACHE_XLEN-1 -: `ICACHE_TAG_BITS];

endmodule

`default_nettype wire

// ==== source/icache_top.sv ====
/*
  Instruction cache top: controller, generated ways and way merge
*/
`default_nettype none

`include "icache_params.svh"

module icache_top (
  input  logic                   clk,
  input  logic                   rstn,
  input  icache_pkg::fetch_req_t fetch_req,
  output logic                   fetch_ready,
  input  logic                   cache_flush,
  output icache_pkg::parcel_t    parcel,
  output icache_pkg::bus_req_t   bus_req,
  input  logic                   bus_ack,
  input  icache_pkg::bus_rsp_t   bus_rsp
);
  import icache_pkg::*;

  way_wr_t                 way_wr;
  way_rd_t                 way_rd;
  tag_entry_t              tag_out  [`ICACHE_WAYS];
  word_t                   data_out [`ICACHE_WAYS];
  logic [`ICACHE_WAYS-1:0] hit;
  logic [`ICACHE_WAYS-1:0] victim;
  logic                    cache_hit;
  word_t                   hit_data;

  icache_ctrl ctrl_i (
    .clk         (clk),
    .rstn        (rstn),
    .fetch_req   (fetch_req),
    .fetch_ready (fetch_ready),
    .cache_flush (cache_flush),
    .parcel      (parcel),
    .bus_req     (bus_req),
    .bus_ack     (bus_ack),
    .bus_rsp     (bus_rsp),
    .cache_hit   (cache_hit),
    .hit_data    (hit_data),
    .way_wr      (way_wr),
    .way_rd      (way_rd)
  );

  genvar w;

  generate
    for (w = 0; w < `ICACHE_WAYS; w++) begin : g_way
      icache_way way_i (
        .clk        (clk),
        .rstn       (rstn),
        .way_wr     (way_wr),
        .way_rd     (way_rd),
        .victim_sel (victim[w]),
        .tag_out    (tag_out[w]),
        .data_out   (data_out[w]),
        .hit        (hit[w])
      );
    end
  endgenerate

  icache_way_merge way_merge_i (
    .tag_out   (tag_out),
    .data_out  (data_out),
    .hit       (hit),
    .cache_hit (cache_hit),
    .hit_data  (hit_data),
    .victim    (victim)
  );

endmodule

`default_nettype wire

// ==== verification/icache_assert.sv ====
/*
  Bus handshake and pipeline rules checked on the cache top level
*/
`default_nettype none

module icache_assert (
  input logic                 clk,
  input logic                 rstn,
  input logic                 fetch_ready,
  input logic                 flushing,          // Controller in its invalidate pass
  input icache_pkg::parcel_t  parcel,
  input icache_pkg::bus_req_t bus_req,
  input logic                 bus_ack
);
  timeunit 1ns;
  timeprecision 100ps;

  // Request phase ends only on bus_ack
  a_stb_hold: assert property (@(posedge clk) disable iff (!rstn)
    bus_req.stb && !bus_ack |=> bus_req.stb)
    else $error("Bus strobe dropped before bus_ack");

  a_adr_hold: assert property (@(posedge clk) disable iff (!rstn)
    bus_req.stb && !bus_ack |=> $stable(bus_req.adr))
    else $error("Bus address changed during the request phase");

  // Nothing to return while sets are being invalidated
  a_no_parcel_flush: assert property (@(posedge clk) disable iff (!rstn)
    flushing |-> !parcel.valid)
    else $error("Parcel valid during flush");

  a_ready_low_stb: assert property (@(posedge clk) disable iff (!rstn)
    bus_req.stb |-> !fetch_ready)
    else $error("fetch_ready high while the bus strobe is high");

endmodule

bind icache_top icache_assert assert_i (
  .clk         (clk),
  .rstn        (rstn),
  .fetch_ready (fetch_ready),
  .flushing    (way_wr.flush),
  .parcel      (parcel),
  .bus_req     (bus_req),
  .bus_ack     (bus_ack)
);

`default_nettype wire

// ==== verification/icache_tb.sv ====
/*
  Instruction cache testbench running the golden fetch sequence against
  an LFSR-delayed wrapping burst model
*/
`default_nettype none

`include "icache_params.svh"

module icache_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import icache_pkg::*;

  localparam int          GOLDEN_DEPTH      = 256;
  localparam int          CYCLES_PER_RECORD = 64;
  localparam int          NUM_TESTS         = 5;
  localparam int          LINE_BYTES        = `ICACHE_LINE_WORDS * 4;
  localparam logic [15:0] LFSR_SEED         = 16'd39408;

  // One outstanding fetch
  typedef struct packed {
    int    test;
    word_t pc;
    word_t word;
    logic  miss;
    int    reqs;                                    // Bus requests seen at issue
  } expect_t;

  logic        clk = 1'b0;
  logic        rstn;
  fetch_req_t  fetch_req;
  logic        fetch_ready;
  logic        cache_flush;
  parcel_t     parcel;
  bus_req_t    bus_req;
  logic        bus_ack;
  bus_rsp_t    bus_rsp;

  word_t       golden [GOLDEN_DEPTH];
  word_t       mem_image [word_t];                  // Listed words only
  int          record_count;
  int          golden_bad;
  expect_t     exp_q [$];
  int          rd_idx;                              // Next entry the checker takes
  int          req_count;
  int          stray_parcels;
  int          stray_reqs;
  int          checks [NUM_TESTS+1];
  int          errors [NUM_TESTS+1];
  logic [15:0] lfsr;

  always #20 clk = ~clk;                            // 40 ns period

  icache_top dut_i (
    .clk         (clk),
    .rstn        (rstn),
    .fetch_req   (fetch_req),
    .fetch_ready (fetch_ready),
    .cache_flush (cache_flush),
    .parcel      (parcel),
    .bus_req     (bus_req),
    .bus_ack     (bus_ack),
    .bus_rsp     (bus_rsp)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Unlisted words get a pattern unique to the address
  function automatic word_t mem_read(input word_t adr);
    if (mem_image.exists(adr)) begin
      return mem_image[adr];
    end
    return {adr[15:0], adr[31:16]} ^ 32'h9e37_79b9;
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1:       return "cold_miss";
      2:       return "line_hits";
      3:       return "fifo_replace";
      4:       return "critical_word";
      5:       return "flush_refill";
      default: return "unknown";
    endcase
  endfunction

  // 0 to 3 idle cycles from two LFSR bits
  task automatic bus_idle();
    int n;
    int b;
    n = 0;
    for (b = 0; b < 2; b++) begin
      lfsr = lfsr_step(lfsr);
      n    = n * 2 + int'(lfsr[0]);
    end
    repeat (n) @(negedge clk);
  endtask

  // Hold the request until the cache takes it
  task automatic issue_fetch(input int id, input word_t pc, input word_t word,
                             input logic miss);
    expect_t e;
    @(negedge clk);
    fetch_req.valid = 1'b1;
    fetch_req.pc    = pc;
    #1;                                             // Sample after inputs settle
    while (!fetch_ready) begin
      @(negedge clk);
      #1;
    end
    e.test = id;
    e.pc   = pc;
    e.word = word;
    e.miss = miss;
    e.reqs = req_count;
    exp_q.push_back(e);                             // Taken at the next rising edge
  endtask

  task automatic request_flush();
    @(negedge clk);
    cache_flush = 1'b1;                             // Held by the cache after one cycle
    @(negedge clk);
    cache_flush = 1'b0;
  endtask

  // Drain outstanding parcels and report the test
  task automatic finish_test(input int id);
    if (id != 0) begin
      @(negedge clk);
      fetch_req.valid = 1'b0;
      while (rd_idx < exp_q.size()) begin
        @(negedge clk);
      end
      $display("Test %s finished: %0d checks, %0d errors",
               test_name(id), checks[id], errors[id]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus model answering with a wrapping burst from the critical word

  initial begin : bus_model
    word_t crit;
    word_t base;
    int    i;
    int    last;
    lfsr       = LFSR_SEED;
    req_count  = 0;
    stray_reqs = 0;
    bus_ack    = 1'b0;
    bus_rsp    = '0;
    forever begin
      @(negedge clk);
      if (bus_req.stb) begin
        // The newest fetch issued is the one that missed
        last = exp_q.size() - 1;
        if (last < 0) begin
          $display("Bus request for %h arrived with no fetch issued", bus_req.adr);
          stray_reqs++;
        end else begin
          checks[exp_q[last].test]++;
          if (bus_req.adr !== exp_q[last].pc) begin
            $display("FAILED %s: critical word address expected %h, actual %h",
                     test_name(exp_q[last].test), exp_q[last].pc, bus_req.adr);
            errors[exp_q[last].test]++;
          end
        end
        bus_idle();                                 // Late ack
        crit    = bus_req.adr;
        base    = crit & ~word_t'(LINE_BYTES - 1);
        bus_ack = 1'b1;
        req_count++;
        @(negedge clk);
        bus_ack = 1'b0;
        for (i = 0; i < `ICACHE_LINE_WORDS; i++) begin
          bus_idle();                               // Gap before each word
          bus_rsp.rack = 1'b1;
          bus_rsp.adr  = base | ((crit + word_t'(4 * i)) & word_t'(LINE_BYTES - 1));
          bus_rsp.dat  = mem_read(bus_rsp.adr);
          @(negedge clk);
          bus_rsp = '0;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Parcel checker on the falling edge

  initial begin : parcel_check
    expect_t e;
    int      t;
    rd_idx        = 0;
    stray_parcels = 0;
    for (t = 0; t <= NUM_TESTS; t++) begin
      checks[t] = 0;
      errors[t] = 0;
    end
    forever begin
      @(negedge clk);
      if (rstn && parcel.valid) begin
        if (rd_idx >= exp_q.size()) begin
          $display("Parcel for pc %h arrived with no fetch outstanding", parcel.pc);
          stray_parcels++;
        end else begin
          e = exp_q[rd_idx];
          rd_idx++;
          checks[e.test]++;
          if (parcel.pc !== e.pc) begin
            $display("FAILED %s: parcel pc expected %h, actual %h",
                     test_name(e.test), e.pc, parcel.pc);
            errors[e.test]++;
          end
          if (parcel.word !== e.word) begin
            $display("FAILED %s: word at %h expected %h, actual %h",
                     test_name(e.test), e.pc, e.word, parcel.word);
            errors[e.test]++;
          end
          if (req_count - e.reqs != (e.miss ? 1 : 0)) begin
            $display("FAILED %s: bus requests for %h expected %0d, actual %0d",
                     test_name(e.test), e.pc, e.miss ? 1 : 0, req_count - e.reqs);
            errors[e.test]++;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus from the golden file

  initial begin : stimulus
    int pos;
    int cur_test;
    int total_checks;
    int total_errors;
    int t;
    rstn        = 1'b0;
    fetch_req   = '0;
    cache_flush = 1'b0;
    golden_bad  = 0;
    $readmemh("verification/icache_golden.txt", golden);

    // Count records and load the memory image
    record_count = 0;
    pos          = 0;
    while (pos < GOLDEN_DEPTH - 5 && golden[pos] != 32'h3) begin
      case (golden[pos])
        32'h0: begin
          mem_image[golden[pos+1]] = golden[pos+2];
          pos += 3;
        end
        32'h1:   pos += 5;
        32'h2:   pos += 2;
        default: begin
          $display("Golden file has an unknown record kind %h at word %0d", golden[pos], pos);
          golden_bad++;
          pos = GOLDEN_DEPTH;
        end
      endcase
      record_count++;
    end

    repeat (4) @(negedge clk);
    rstn = 1'b1;                                    // Reset flush starts here

    cur_test = 0;
    pos      = 0;
    while (pos < GOLDEN_DEPTH - 5 && golden[pos] != 32'h3) begin
      case (golden[pos])
        32'h1: begin
          if (int'(golden[pos+1]) != cur_test) begin
            finish_test(cur_test);
            cur_test = int'(golden[pos+1]);
          end
          issue_fetch(cur_test, golden[pos+2], golden[pos+3], golden[pos+4][0]);
          pos += 5;
        end
        32'h2: begin
          if (int'(golden[pos+1]) != cur_test) begin
            finish_test(cur_test);
            cur_test = int'(golden[pos+1]);
          end
          request_flush();
          pos += 2;
        end
        32'h0:   pos += 3;
        default: pos = GOLDEN_DEPTH;
      endcase
    end
    finish_test(cur_test);

    total_checks = 0;
    total_errors = stray_parcels + stray_reqs + golden_bad;
    for (t = 1; t <= NUM_TESTS; t++) begin
      total_checks += checks[t];
      total_errors += errors[t];
    end
    $display("Summary: %0d checks, %0d errors, %0d stray parcels, %0d stray requests",
             total_checks, total_errors, stray_parcels, stray_reqs);
    if (total_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Limit scales with the golden file length
  initial begin : watchdog
    #1;
    repeat (record_count * CYCLES_PER_RECORD) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles",
             record_count * CYCLES_PER_RECORD);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== icache_top.f ====
+incdir+source
source/icache_pkg.sv
source/icache_ram_1r1w.sv
source/icache_way.sv
source/icache_way_merge.sv
source/icache_ctrl.sv
source/icache_top.sv
verification/icache_assert.sv
verification/icache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
  --top-module icache_tb \
  -Mdir "$build_dir" -o icache_sim \
  -f icache_top.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/icache_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "No errors" "$log_file"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

// ==== verification/icache_golden.txt ====
// Kinds: 0 memory word (addr data), 1 fetch (test addr word miss), 2 flush (test), 3 end
// Tests: 1 cold miss, 2 line hits, 3 FIFO replace, 4 critical word, 5 flush and refill
// Memory image
0 00001000 00100093
0 00001004 00200113
0 00001008 00308193
0 0000100c 00410213
0 00002030 02a00293
0 00003030 03b00313
0 00004030 04c00393
0 000050a0 00b50533
0 000050a4 40b50533
0 000050a8 00c585b3
0 000050ac 40c585b3
0 000060b8 0000006f
// Fetch and flush sequence
1 1 00001008 00308193 1
1 2 00001000 00100093 0
1 2 00001004 00200113 0
1 2 0000100c 00410213 0
1 2 00001008 00308193 0
1 2 00001008 00308193 0
1 3 00002030 02a00293 1
1 3 00003030 03b00313 1
1 3 00004030 04c00393 1
1 3 00002030 02a00293 1
1 3 00004030 04c00393 0
1 3 00003030 03b00313 1
1 3 00002030 02a00293 0
1 4 000050a4 40b50533 1
1 4 000050a0 00b50533 0
1 4 000050ac 40c585b3 0
1 4 000050a8 00c585b3 0
1 4 000060b8 0000006f 1
2 5
1 5 00001004 00200113 1
1 5 00001000 00100093 0
1 5 00001008 00308193 0
3
